// ==== sim.f ====
+incdir+include
design/husky_pkg.sv
design/husky_ifs.sv
design/usb_reg_port.sv
design/reg_control_bank.sv
design/capture_fifo.sv
design/fifo_read_port.sv
design/husky_reg_top.sv
sim/tb_husky_reg_top.sv

// ==== Makefile ====
# Verilator simulation of the host register path and capture FIFO

VERILATOR ?= verilator
TOP       ?= tb_husky_reg_top
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "Test completed successfully" $(LOG) || \
		{ echo "simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== sim/tb_husky_reg_top.sv ====
`timescale 1ns/10ps
`include "husky_settings.svh"

module tb_husky_reg_top;

   localparam int CLK_PERIOD = 40;
   localparam int RD_LATENCY = 3;    // valid at edge N+2, seen on the negedge after it
   localparam int RD_TIMEOUT = 8;
   localparam int T_RAND     = 20;   // random traffic cycles per source test
   localparam int T_FULL     = 24;
   localparam int T_FLUSH    = 6;
   localparam int T_REFILL   = 8;
   localparam int LED_WATCH  = 48;   // three flash periods
   localparam int TRAFFIC_CYCLES = 2 * T_RAND + T_FULL + T_FLUSH + T_REFILL + 5;
   localparam int HOST_READS     = 4 * (3 * `FIFO_DEPTH + 2) + 16;
   localparam int HOST_WRITES    = 12;
   localparam int RUN_CYCLES = 10 + TRAFFIC_CYCLES + 6 * HOST_READS + 3 * HOST_WRITES
                               + 2 * LED_WATCH;

   logic                    clk_usb_buf;
   logic                    rst;
   logic [`REG_ADDR_W-1:0]  usb_addr;
   logic [`REG_DATA_W-1:0]  usb_wdata;
   logic                    usb_rdn;
   logic                    usb_wrn;
   logic                    usb_cen;
   logic [`REG_DATA_W-1:0]  usb_data;
   logic                    usb_rd_valid;
   logic                    trace_valid;
   logic [`FIFO_WORD_W-1:0] trace_data;
   logic                    trace_ready;
   logic                    la_valid;
   logic [`FIFO_WORD_W-1:0] la_data;
   logic                    la_ready;
   logic                    led_error;

   logic [`FIFO_WORD_W-1:0] model_q [$];   // words accepted by the FIFO, oldest first
   logic                    model_err;
   logic [31:0]             lfsr = 32'h8c84;
   int                      errors;
   int                      checks;
   int                      tests;
   int                      test_err_start;

   husky_reg_top i_dut (
      .clk_usb_buf    (clk_usb_buf),
      .rst_i          (rst),
      .usb_addr_i     (usb_addr),
      .usb_wdata_i    (usb_wdata),
      .usb_rdn_i      (usb_rdn),
      .usb_wrn_i      (usb_wrn),
      .usb_cen_i      (usb_cen),
      .usb_data_o     (usb_data),
      .usb_rd_valid_o (usb_rd_valid),
      .trace_valid_i  (trace_valid),
      .trace_data_i   (trace_data),
      .trace_ready_o  (trace_ready),
      .la_valid_i     (la_valid),
      .la_data_i      (la_data),
      .la_ready_o     (la_ready),
      .led_error_o    (led_error)
   );

   initial begin
      clk_usb_buf = 1'b0;
      forever #(CLK_PERIOD / 2) clk_usb_buf = ~clk_usb_buf;
   end

   // x^32 + x^22 + x^2 + x + 1, one step per bit
   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
         r    = {r[30:0], lfsr[0]};
      end
      return r;
   endfunction

   task automatic check_val(input string name, input logic [7:0] got, input logic [7:0] exp);
      checks++;
      assert (got === exp) else begin
         $display("Mismatch %s: got %h, expected %h", name, got, exp);
         errors++;
      end
   endtask

   task automatic expect_true(input bit cond, input string what);
      checks++;
      assert (cond) else begin
         $display("%s", what);
         errors++;
      end
   endtask

   task automatic finish_test(input string name);
      tests++;
      $display("%s finished with %0d errors", name, errors - test_err_start);
      test_err_start = errors;
   endtask

   task automatic host_write(input logic [7:0] addr, input logic [7:0] data);
      @(negedge clk_usb_buf);
      usb_addr  = addr;
      usb_wdata = data;
      usb_wrn   = 1'b0;
      usb_cen   = 1'b0;
      @(negedge clk_usb_buf);
      usb_wrn = 1'b1;
      usb_cen = 1'b1;
      @(negedge clk_usb_buf);   // register written at edge N+1
   endtask

   task automatic host_read(input logic [7:0] addr, output logic [7:0] data);
      int waited;
      waited = 0;
      data   = '0;
      @(negedge clk_usb_buf);
      usb_addr = addr;
      usb_rdn  = 1'b0;
      usb_cen  = 1'b0;
      do begin
         @(negedge clk_usb_buf);
         waited++;
      end while (!usb_rd_valid && waited < RD_TIMEOUT);
      expect_true(usb_rd_valid, "no usb_rd_valid_o after a host read");
      if (usb_rd_valid) begin
         check_val("usb_rd_valid_o latency", 8'(waited), 8'(RD_LATENCY));
         data = usb_data;
      end
      usb_rdn = 1'b1;
      usb_cen = 1'b1;
      @(negedge clk_usb_buf);
      check_val("usb_rd_valid_o", {7'b0, usb_rd_valid}, 8'h00);   // one cycle only
   endtask

   task automatic check_status();
      logic [7:0] d;
      logic [7:0] exp;
      host_read(husky_pkg::REG_STATUS, d);
      exp = {`FIFO_CNT_W'(model_q.size()), model_err,
             model_q.size() == `FIFO_DEPTH, model_q.size() == 0};
      check_val("usb_data_o STATUS", d, exp);
   endtask

   task automatic drain_fifo();
      logic [`FIFO_WORD_W-1:0] w;
      logic [7:0]              d;
      logic [7:0]              exp_b [3];
      check_status();
      while (model_q.size() > 0) begin
         w        = model_q.pop_front();
         exp_b[0] = w[7:0];
         exp_b[1] = w[15:8];
         exp_b[2] = {6'b0, w[17:16]};
         for (int b = 0; b < 3; b++) begin
            host_read(husky_pkg::REG_FIFO_DATA, d);
            check_val("usb_data_o FIFO_DATA", d, exp_b[b]);
         end
      end
      check_status();
   endtask

   // both sources hold valid and data until their word is taken
   // capture is on here, so the selected source is ready while the FIFO has room
   task automatic run_traffic(input int cycles, input bit sel_la, input bit always_valid);
      bit t_xfer;
      bit l_xfer;
      bit room;
      t_xfer = 1'b0;
      l_xfer = 1'b0;
      repeat (cycles) begin
         @(negedge clk_usb_buf);
         if (!trace_valid || t_xfer) begin
            trace_valid = always_valid | 1'(take_bits(1));
            trace_data  = `FIFO_WORD_W'(take_bits(`FIFO_WORD_W));
         end
         if (!la_valid || l_xfer) begin
            la_valid = always_valid | 1'(take_bits(1));
            la_data  = `FIFO_WORD_W'(take_bits(`FIFO_WORD_W));
         end
         room = (model_q.size() < `FIFO_DEPTH);
         if (sel_la) begin
            check_val("trace_ready_o", {7'b0, trace_ready}, 8'h00);
            check_val("la_ready_o", {7'b0, la_ready}, {7'b0, room});
         end else begin
            check_val("la_ready_o", {7'b0, la_ready}, 8'h00);
            check_val("trace_ready_o", {7'b0, trace_ready}, {7'b0, room});
         end
         t_xfer = trace_valid && trace_ready;   // taken on the coming rising edge
         l_xfer = la_valid && la_ready;
         if (t_xfer) model_q.push_back(trace_data);
         if (l_xfer) model_q.push_back(la_data);
      end
      @(negedge clk_usb_buf);
      trace_valid = 1'b0;
      la_valid    = 1'b0;
   endtask

   task automatic watch_led(input int cycles, output int highs);
      highs = 0;
      repeat (cycles) begin
         @(negedge clk_usb_buf);
         if (led_error) highs++;
      end
   endtask

   initial begin : main
      logic [7:0] d;
      logic [7:0] v;
      int         highs;
      errors = 0;
      checks = 0;
      tests = 0;
      test_err_start = 0;
      model_err = 1'b0;
      rst = 1'b1;
      usb_addr = '0;
      usb_wdata = '0;
      usb_rdn = 1'b1;
      usb_wrn = 1'b1;
      usb_cen = 1'b1;
      trace_valid = 1'b0;
      trace_data = '0;
      la_valid = 1'b0;
      la_data = '0;
      repeat (10) @(posedge clk_usb_buf);
      @(negedge clk_usb_buf);
      rst = 1'b0;

      check_val("trace_ready_o", {7'b0, trace_ready}, 8'h00);
      check_val("la_ready_o", {7'b0, la_ready}, 8'h00);
      check_val("usb_rd_valid_o", {7'b0, usb_rd_valid}, 8'h00);
      check_val("led_error_o", {7'b0, led_error}, 8'h00);
      check_status();
      host_read(husky_pkg::REG_ID, d);
      check_val("usb_data_o ID", d, `HUSKY_ID);
      host_read(8'hA7, d);
      check_val("usb_data_o unmapped", d, 8'h00);
      v = 8'(take_bits(2));
      host_write(husky_pkg::REG_CTRL, v);
      host_read(husky_pkg::REG_CTRL, d);
      check_val("usb_data_o CTRL", d, v);
      finish_test("register access");

      host_write(husky_pkg::REG_CTRL, 8'h02);   // trace, capture on
      run_traffic(T_RAND, 1'b0, 1'b0);
      drain_fifo();
      finish_test("trace capture");

      host_write(husky_pkg::REG_CTRL, 8'h03);   // LA, capture on
      run_traffic(T_RAND, 1'b1, 1'b0);
      drain_fifo();
      finish_test("LA capture");

      host_write(husky_pkg::REG_CTRL, 8'h02);
      run_traffic(T_FULL, 1'b0, 1'b1);
      expect_true(model_q.size() == `FIFO_DEPTH, "FIFO did not fill under continuous valid");
      check_val("trace_ready_o", {7'b0, trace_ready}, 8'h00);
      drain_fifo();
      finish_test("back-pressure");

      host_read(husky_pkg::REG_FIFO_DATA, d);
      model_err = 1'b1;
      check_val("usb_data_o FIFO_DATA empty", d, 8'h00);
      check_status();
      watch_led(LED_WATCH, highs);
      expect_true(highs > 0 && highs < LED_WATCH, "led_error_o did not flash on error");
      host_write(husky_pkg::REG_CMD, 8'h02);
      model_err = 1'b0;
      watch_led(LED_WATCH, highs);
      expect_true(highs == 0, "led_error_o still on after clearing the error");
      check_status();
      finish_test("empty read error");

      run_traffic(T_FLUSH, 1'b0, 1'b1);
      host_read(husky_pkg::REG_FIFO_DATA, d);   // leaves the byte select mid-word
      check_val("usb_data_o FIFO_DATA", d, model_q[0][7:0]);
      host_write(husky_pkg::REG_CMD, 8'h01);
      model_q.delete();
      check_status();
      run_traffic(T_REFILL, 1'b0, 1'b0);
      drain_fifo();
      finish_test("flush");

      $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

   initial begin : watchdog
      #(2 * RUN_CYCLES * CLK_PERIOD);
      $display("watchdog expired before the tests finished");
      $display("Test failed");
      $finish;
   end

endmodule

// ==== design/husky_reg_top.sv ====
`timescale 1ns/10ps
`include "husky_settings.svh"

module husky_reg_top (
   input  logic                    clk_usb_buf,
   input  logic                    rst_i,
   input  logic [`REG_ADDR_W-1:0]  usb_addr_i,
   input  logic [`REG_DATA_W-1:0]  usb_wdata_i,
   input  logic                    usb_rdn_i,
   input  logic                    usb_wrn_i,
   input  logic                    usb_cen_i,
   output logic [`REG_DATA_W-1:0]  usb_data_o,
   output logic                    usb_rd_valid_o,
   input  logic                    trace_valid_i,
   input  logic [`FIFO_WORD_W-1:0] trace_data_i,
   output logic                    trace_ready_o,
   input  logic                    la_valid_i,
   input  logic [`FIFO_WORD_W-1:0] la_data_i,
   output logic                    la_ready_o,
   output logic                    led_error_o
);

   logic [`REG_DATA_W-1:0]  ctrl_rdata;
   logic [`REG_DATA_W-1:0]  fifo_rdata;
   husky_pkg::capture_src_e capture_src;
   logic                    capture_en;
   logic                    flush;
   logic                    underrun;

   reg_bus_if bus ();
   fifo_rd_if fifo ();

   usb_reg_port i_usb_reg_port (
      .clk_usb_buf    (clk_usb_buf),
      .rst_i          (rst_i),
      .usb_addr_i     (usb_addr_i),
      .usb_wdata_i    (usb_wdata_i),
      .usb_rdn_i      (usb_rdn_i),
      .usb_wrn_i      (usb_wrn_i),
      .usb_cen_i      (usb_cen_i),
      .ctrl_rdata_i   (ctrl_rdata),
      .fifo_rdata_i   (fifo_rdata),
      .usb_data_o     (usb_data_o),
      .usb_rd_valid_o (usb_rd_valid_o),
      .bus            (bus.master)
   );

   reg_control_bank i_reg_control_bank (
      .clk_usb_buf   (clk_usb_buf),
      .rst_i         (rst_i),
      .underrun_i    (underrun),
      .capture_src_o (capture_src),
      .capture_en_o  (capture_en),
      .flush_o       (flush),
      .rdata_o       (ctrl_rdata),
      .led_error_o   (led_error_o),
      .bus           (bus.slave),
      .fifo          (fifo.status)
   );

   // shared by trace and LA, one source at a time
   capture_fifo i_capture_fifo (
      .clk_usb_buf   (clk_usb_buf),
      .rst_i         (rst_i),
      .capture_src_i (capture_src),
      .capture_en_i  (capture_en),
      .flush_i       (flush),
      .trace_valid_i (trace_valid_i),
      .trace_data_i  (trace_data_i),
      .la_valid_i    (la_valid_i),
      .la_data_i     (la_data_i),
      .trace_ready_o (trace_ready_o),
      .la_ready_o    (la_ready_o),
      .rd            (fifo.fifo)
   );

   fifo_read_port i_fifo_read_port (
      .clk_usb_buf (clk_usb_buf),
      .rst_i       (rst_i),
      .flush_i     (flush),
      .rdata_o     (fifo_rdata),
      .underrun_o  (underrun),
      .bus         (bus.slave),
      .fifo        (fifo.reader)
   );

endmodule

// ==== design/fifo_read_port.sv ====
`timescale 1ns/10ps
`include "husky_settings.svh"

module fifo_read_port (
   input  logic                   clk_usb_buf,
   input  logic                   rst_i,
   input  logic                   flush_i,
   output logic [`REG_DATA_W-1:0] rdata_o,
   output logic                   underrun_o,
   reg_bus_if.slave               bus,
   fifo_rd_if.reader              fifo
);

   localparam int HI_W = `FIFO_WORD_W - 16;   // bits left for the top byte

   husky_pkg::byte_sel_e   byte_sel;
   logic                   data_rd;
   logic                   byte_rd;
   logic [`REG_DATA_W-1:0] cur_byte;

   assign data_rd    = bus.read && (bus.addr == husky_pkg::REG_FIFO_DATA);
   assign byte_rd    = data_rd & ~fifo.empty;
   assign underrun_o = data_rd & fifo.empty;   // host read ahead of the data

   // last byte consumed, release the word
   assign fifo.pop = byte_rd && (byte_sel == husky_pkg::BYTE_HI);

   always_comb begin
      case (byte_sel)
         husky_pkg::BYTE_LO:  cur_byte = fifo.word[7:0];
         husky_pkg::BYTE_MID: cur_byte = fifo.word[15:8];
         default:             cur_byte = {{(`REG_DATA_W-HI_W){1'b0}}, fifo.word[`FIFO_WORD_W-1:16]};
      endcase
   end

   always_ff @(posedge clk_usb_buf) begin
      if (rst_i) begin
         byte_sel <= husky_pkg::BYTE_LO;
      end else if (flush_i) begin
         byte_sel <= husky_pkg::BYTE_LO;
      end else if (byte_rd) begin
         case (byte_sel)
            husky_pkg::BYTE_LO:  byte_sel <= husky_pkg::BYTE_MID;
            husky_pkg::BYTE_MID: byte_sel <= husky_pkg::BYTE_HI;
            default:             byte_sel <= husky_pkg::BYTE_LO;
         endcase
      end
   end

   // empty reads return 0 like an unaddressed block
   always_ff @(posedge clk_usb_buf) begin
      rdata_o <= byte_rd ? cur_byte : '0;
   end

endmodule

// ==== design/capture_fifo.sv ====
`timescale 1ns/10ps
`include "husky_settings.svh"

module capture_fifo (
   input  logic                    clk_usb_buf,
   input  logic                    rst_i,
   input  husky_pkg::capture_src_e capture_src_i,
   input  logic                    capture_en_i,
   input  logic                    flush_i,
   input  logic                    trace_valid_i,
   input  logic [`FIFO_WORD_W-1:0] trace_data_i,
   input  logic                    la_valid_i,
   input  logic [`FIFO_WORD_W-1:0] la_data_i,
   output logic                    trace_ready_o,
   output logic                    la_ready_o,
   fifo_rd_if.fifo                 rd
);

   localparam int PTR_W = $clog2(`FIFO_DEPTH);

   logic [`FIFO_WORD_W-1:0] mem [`FIFO_DEPTH];
   logic [PTR_W-1:0]        wr_ptr;
   logic [PTR_W-1:0]        rd_ptr;
   logic [`FIFO_CNT_W-1:0]  count_q;
   logic                    la_sel;
   logic                    accept;
   logic                    push;
   logic                    do_pop;
   logic [`FIFO_WORD_W-1:0] push_data;

   assign la_sel = (capture_src_i == husky_pkg::SRC_LA);
   assign accept = capture_en_i & ~rd.full;

   // unselected source never sees ready
   assign trace_ready_o = accept & ~la_sel;
   assign la_ready_o    = accept & la_sel;

   assign push      = la_sel ? (la_valid_i & la_ready_o) : (trace_valid_i & trace_ready_o);
   assign push_data = la_sel ? la_data_i : trace_data_i;
   assign do_pop    = rd.pop & ~rd.empty;

   assign rd.word  = mem[rd_ptr];   // head word, read without latency
   assign rd.count = count_q;
   assign rd.empty = (count_q == '0);
   assign rd.full  = (count_q == `FIFO_CNT_W'(`FIFO_DEPTH));

   always_ff @(posedge clk_usb_buf) begin
      if (push) begin
         mem[wr_ptr] <= push_data;
      end
   end

   always_ff @(posedge clk_usb_buf) begin
      if (rst_i) begin
         wr_ptr  <= '0;
         rd_ptr  <= '0;
         count_q <= '0;
      end else if (flush_i) begin
         wr_ptr  <= '0;   // contents are simply abandoned
         rd_ptr  <= '0;
         count_q <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;   // wraps, depth is a power of two
         end
         if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         if (push && !do_pop) begin
            count_q <= count_q + 1'b1;
         end else if (do_pop && !push) begin
            count_q <= count_q - 1'b1;
         end
      end
   end

endmodule

// ==== design/reg_control_bank.sv ====
`timescale 1ns/10ps
`include "husky_settings.svh"

module reg_control_bank (
   input  logic                    clk_usb_buf,
   input  logic                    rst_i,
   input  logic                    underrun_i,
   output husky_pkg::capture_src_e capture_src_o,
   output logic                    capture_en_o,
   output logic                    flush_o,
   output logic [`REG_DATA_W-1:0]  rdata_o,
   output logic                    led_error_o,
   reg_bus_if.slave                bus,
   fifo_rd_if.status               fifo
);

   logic                ctrl_wr;
   logic                cmd_wr;
   logic                error_q;     // sticky until cleared by CMD bit 1
   logic [`FLASH_BIT:0] flash_cnt;   // free running

   assign ctrl_wr = bus.write && (bus.addr == husky_pkg::REG_CTRL);
   assign cmd_wr  = bus.write && (bus.addr == husky_pkg::REG_CMD);

   assign flush_o     = cmd_wr & bus.wdata[0];   // lasts the write cycle only
   assign led_error_o = error_q & flash_cnt[`FLASH_BIT];

   always_ff @(posedge clk_usb_buf) begin
      if (rst_i) begin
         capture_src_o <= husky_pkg::SRC_TRACE;
         capture_en_o  <= 1'b0;
         error_q       <= 1'b0;
         flash_cnt     <= '0;
      end else begin
         flash_cnt <= flash_cnt + 1'b1;
         if (ctrl_wr) begin
            capture_src_o <= husky_pkg::capture_src_e'(bus.wdata[0]);
            capture_en_o  <= bus.wdata[1];
         end
         if (underrun_i) begin
            error_q <= 1'b1;
         end else if (cmd_wr && bus.wdata[1]) begin
            error_q <= 1'b0;
         end
      end
   end

   // read byte, registered at the end of the read cycle
   always_ff @(posedge clk_usb_buf) begin
      rdata_o <= '0;
      if (bus.read) begin
         case (bus.addr)
            husky_pkg::REG_CTRL: begin
               rdata_o <= {{(`REG_DATA_W-2){1'b0}}, capture_en_o, capture_src_o};
            end
            husky_pkg::REG_STATUS: begin
               rdata_o <= {fifo.count, error_q, fifo.full, fifo.empty};
            end
            husky_pkg::REG_ID: begin
               rdata_o <= `HUSKY_ID;
            end
            default: begin
               rdata_o <= '0;   // CMD and unmapped addresses
            end
         endcase
      end
   end

endmodule

// ==== design/usb_reg_port.sv ====
`timescale 1ns/10ps
`include "husky_settings.svh"

module usb_reg_port (
   input  logic                   clk_usb_buf,
   input  logic                   rst_i,
   input  logic [`REG_ADDR_W-1:0] usb_addr_i,
   input  logic [`REG_DATA_W-1:0] usb_wdata_i,
   input  logic                   usb_rdn_i,
   input  logic                   usb_wrn_i,
   input  logic                   usb_cen_i,
   input  logic [`REG_DATA_W-1:0] ctrl_rdata_i,
   input  logic [`REG_DATA_W-1:0] fifo_rdata_i,
   output logic [`REG_DATA_W-1:0] usb_data_o,
   output logic                   usb_rd_valid_o,
   reg_bus_if.master              bus
);

   logic rdn_q;      // strobes as seen on the previous edge
   logic wrn_q;
   logic rd_fall;
   logic wr_fall;
   logic rd_pend;    // blocks return their byte this cycle

   // falling strobe with chip enable low, read wins a tie
   assign rd_fall = rdn_q & ~usb_rdn_i & ~usb_cen_i;
   assign wr_fall = wrn_q & ~usb_wrn_i & ~usb_cen_i & ~rd_fall;

   always_ff @(posedge clk_usb_buf) begin
      if (rst_i) begin
         rdn_q          <= 1'b1;   // strobes idle high
         wrn_q          <= 1'b1;
         bus.read       <= 1'b0;
         bus.write      <= 1'b0;
         rd_pend        <= 1'b0;
         usb_rd_valid_o <= 1'b0;
      end else begin
         rdn_q          <= usb_rdn_i;
         wrn_q          <= usb_wrn_i;
         bus.read       <= rd_fall;
         bus.write      <= wr_fall;
         rd_pend        <= bus.read;
         usb_rd_valid_o <= rd_pend;
      end
   end

   // address and write data held from the strobe edge
   always_ff @(posedge clk_usb_buf) begin
      if (rd_fall | wr_fall) begin
         bus.addr  <= usb_addr_i;
         bus.wdata <= usb_wdata_i;
      end
   end

   // unaddressed blocks return 0, so a plain OR merges them
   always_ff @(posedge clk_usb_buf) begin
      if (rd_pend) begin
         usb_data_o <= ctrl_rdata_i | fifo_rdata_i;
      end
   end

endmodule

// ==== design/husky_ifs.sv ====
`timescale 1ns/10ps
`include "husky_settings.svh"

// single-cycle register access from the host port
interface reg_bus_if;
   logic [`REG_ADDR_W-1:0] addr;
   logic [`REG_DATA_W-1:0] wdata;
   logic                   read;    // one-cycle pulse
   logic                   write;   // one-cycle pulse

   modport master (output addr, output wdata, output read, output write);
   modport slave  (input addr, input wdata, input read, input write);
endinterface

// read side of the capture FIFO
interface fifo_rd_if;
   logic                    pop;    // one-cycle pulse, only when not empty
   logic [`FIFO_WORD_W-1:0] word;   // head word
   logic                    empty;
   logic                    full;
   logic [`FIFO_CNT_W-1:0]  count;

   modport fifo   (input pop, output word, output empty, output full, output count);
   modport reader (output pop, input word, input empty);
   modport status (input empty, input full, input count);
endinterface

// ==== design/husky_pkg.sv ====
`include "husky_settings.svh"

package husky_pkg;

   // host register map
   typedef enum logic [`REG_ADDR_W-1:0] {
      REG_CTRL      = 8'h01,
      REG_CMD       = 8'h02,
      REG_STATUS    = 8'h03,
      REG_FIFO_DATA = 8'h04,
      REG_ID        = 8'h05
   } reg_addr_e;

   // capture source feeding the FIFO
   typedef enum logic {
      SRC_TRACE = 1'b0,
      SRC_LA    = 1'b1
   } capture_src_e;

   // which byte of the head word the host reads next
   typedef enum logic [1:0] {
      BYTE_LO,
      BYTE_MID,
      BYTE_HI
   } byte_sel_e;

endpackage

// ==== include/husky_settings.svh ====
`ifndef HUSKY_SETTINGS_SVH
`define HUSKY_SETTINGS_SVH

// host register bus
`define REG_ADDR_W   8
`define REG_DATA_W   8

// capture FIFO
`define FIFO_WORD_W  18
`define FIFO_DEPTH   16
`define FIFO_CNT_W   5        // holds 0 to FIFO_DEPTH

`define HUSKY_ID     8'h48    // ID register value, ascii H

`define FLASH_BIT    3        // flash counter bit that drives the error LED

`endif
